// File: list.f
design/mdio_frame_pkg.sv
design/mdio_csr_pkg.sv
design/mdio_cmd_if.sv
design/mdio_csr_slave.sv
design/mdio_cmd_buffer.sv
design/mdc_clock_gen.sv
design/mdio_frame_engine.sv
design/mdio_master.sv
tb/mdio_phy_model.sv
tb/tb_mdio_master.sv

// File: Bender.yml
package:
  name: mdio_master

sources:
  - design/mdio_frame_pkg.sv
  - design/mdio_csr_pkg.sv
  - design/mdio_cmd_if.sv
  - design/mdio_csr_slave.sv
  - design/mdio_cmd_buffer.sv
  - design/mdc_clock_gen.sv
  - design/mdio_frame_engine.sv
  - design/mdio_master.sv
  - target: simulation
    files:
      - tb/mdio_phy_model.sv
      - tb/tb_mdio_master.sv

// File: tb/tb_mdio_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mdio_master import mdio_frame_pkg::*, mdio_csr_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int CMD_CYCLES   = 600;
    localparam int MAX_CMDS     = 6;
    localparam int IDLE_CYCLES  = (PREAMBLE_BITS + 4) * MDC_DIVISOR;
    localparam int ACCESS_LIMIT = 2 * CMD_CYCLES;
    localparam int MIN_STALL    = (PREAMBLE_BITS + 2 * MDIO_DATA_W) * MDC_DIVISOR;
    localparam int WATCHDOG_NS  = (MAX_CMDS * CMD_CYCLES + PREAMBLE_BITS * MDC_DIVISOR
                                   + RESET_CYCLES) * CLK_PERIOD;

    logic                   clk;
    logic                   reset;
    logic                   csr_read;
    logic                   csr_write;
    logic [CSR_ADDR_W-1:0]  csr_address;
    logic [CSR_DATA_W-1:0]  csr_writedata;
    logic [CSR_DATA_W-1:0]  csr_readdata;
    logic                   csr_waitrequest;
    logic                   mdc;
    logic                   mdio_in;
    logic                   mdio_out;
    logic                   mdio_oen;
    logic [MDIO_DATA_W-1:0] phy_read_value;

    // Last frame as decoded by the PHY model
    logic [7:0]             seen_pre;
    logic [1:0]             seen_start;
    logic [1:0]             seen_op;
    logic [PHY_ADDR_W-1:0]  seen_phy;
    logic [REG_ADDR_W-1:0]  seen_reg;
    logic [1:0]             seen_ta;
    logic [MDIO_DATA_W-1:0] seen_data;
    logic [31:0]            frame_cnt;
    logic [39:0]            frame_log[$];

    int errors = 0;
    int checks = 0;
    int tests  = 0;

    mdio_master UUT (
        .clk             (clk),
        .reset           (reset),
        .csr_read        (csr_read),
        .csr_write       (csr_write),
        .csr_address     (csr_address),
        .csr_writedata   (csr_writedata),
        .csr_readdata    (csr_readdata),
        .csr_waitrequest (csr_waitrequest),
        .mdc             (mdc),
        .mdio_in         (mdio_in),
        .mdio_out        (mdio_out),
        .mdio_oen        (mdio_oen)
    );

    mdio_phy_model u_phy (
        .mdc        (mdc),
        .mdio_out   (mdio_out),
        .mdio_oen   (mdio_oen),
        .read_value (phy_read_value),
        .mdio_in    (mdio_in),
        .pre_ones   (seen_pre),
        .start_bits (seen_start),
        .op_bits    (seen_op),
        .phy_addr   (seen_phy),
        .reg_addr   (seen_reg),
        .ta_bits    (seen_ta),
        .data       (seen_data),
        .frame_cnt  (frame_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the tests finished", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    // Keep every completed frame in arrival order
    always @(frame_cnt) begin
        if (frame_cnt != 0) begin
            frame_log.push_back({seen_pre, seen_start, seen_op, seen_phy, seen_reg,
                                 seen_ta, seen_data});
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        assert (got === exp) else begin
            $display("[ERROR] %0s: got 0x%h, expected 0x%h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // Avalon-style transfer that completes at the edge where waitrequest is low
    task automatic csr_access(input logic is_write, input logic [CSR_ADDR_W-1:0] addr,
                              input logic [CSR_DATA_W-1:0] wdata,
                              output logic [CSR_DATA_W-1:0] rdata, output int waits);
        int cycles;
        cycles        = 0;
        csr_write     = is_write;
        csr_read      = !is_write;
        csr_address   = addr;
        csr_writedata = wdata;
        @(posedge clk);
        while (csr_waitrequest && cycles < ACCESS_LIMIT) begin
            cycles = cycles + 1;
            @(posedge clk);
        end
        rdata = csr_readdata;
        waits = cycles;
        #1;
        csr_write = 1'b0;
        csr_read  = 1'b0;
        assert (cycles < ACCESS_LIMIT) else begin
            $display("CSR access to address 0x%h was never answered", addr);
            errors = errors + 1;
        end
    endtask

    task automatic wait_for_frames(input int count);
        int cycles;
        cycles = 0;
        while (frame_log.size() < count && cycles < CMD_CYCLES) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
        end
        assert (frame_log.size() >= count) else begin
            $display("Timed out waiting for MDIO frame %0d", count - 1);
            errors = errors + 1;
        end
    endtask

    task automatic check_frame(input int idx, input logic [1:0] exp_op,
                               input logic [PHY_ADDR_W-1:0] exp_phy,
                               input logic [REG_ADDR_W-1:0] exp_reg,
                               input logic [MDIO_DATA_W-1:0] exp_data);
        logic [39:0] rec;
        if (idx >= frame_log.size()) begin
            $display("MDIO frame %0d was not seen on the bus", idx);
            errors = errors + 1;
        end else begin
            rec = frame_log[idx];
            check_value("preamble ones", rec[39:32], PREAMBLE_BITS);
            check_value("start", rec[31:30], 2'b01);
            check_value("opcode", rec[29:28], exp_op);
            check_value("phy_addr", rec[27:23], exp_phy);
            check_value("reg_addr", rec[22:18], exp_reg);
            // Read data is driven by the model and checked at the CSR port
            if (exp_op == op_write) begin
                check_value("turnaround", rec[17:16], 2'b10);
                check_value("mdio data", rec[15:0], exp_data);
            end
        end
    endtask

    task automatic report_test(input string name, input int first_error);
        tests = tests + 1;
        $display("test %0s finished with %0d errors", name, errors - first_error);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        int                     rng_seed;
        int                     first_err;
        int                     waits;
        int                     base;
        int                     cyc;
        int                     last_rise;
        logic                   prev_mdc;
        logic [31:0]            rnd;
        logic [CSR_DATA_W-1:0]  rdata;
        logic [CSR_DATA_W-1:0]  addr_word;
        logic [PHY_ADDR_W-1:0]  phy;
        logic [REG_ADDR_W-1:0]  reg_a;
        logic [REG_ADDR_W-1:0]  reg_b;
        logic [CSR_DATA_W-1:0]  data_a;
        logic [CSR_DATA_W-1:0]  data_b;

        rng_seed       = 32'hd1f7;
        rnd            = $urandom(rng_seed);
        reset          = 1'b1;
        csr_read       = 1'b0;
        csr_write      = 1'b0;
        csr_address    = '0;
        csr_writedata  = '0;
        phy_read_value = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle line and MDC period while the reset preamble runs
        first_err = errors;
        check_value("csr_waitrequest", csr_waitrequest, 1'b1);
        check_value("csr_readdata", csr_readdata, '0);
        last_rise = -1;
        prev_mdc  = mdc;
        for (cyc = 0; cyc < IDLE_CYCLES; cyc++) begin
            @(posedge clk);
            check_value("mdio_oen", mdio_oen, 1'b1);
            check_value("mdio_out", mdio_out, 1'b1);
            if (mdc && !prev_mdc) begin
                if (last_rise >= 0) begin
                    check_value("mdc period", cyc - last_rise, MDC_DIVISOR);
                end
                last_rise = cyc;
            end
            prev_mdc = mdc;
            #1;
        end
        report_test("idle_after_reset", first_err);

        first_err = errors;
        addr_word = $urandom;
        csr_access(1'b1, CSR_PHY_ADDR_REG, addr_word, rdata, waits);
        check_value("csr_waitrequest cycles", waits, 1);
        csr_access(1'b0, CSR_PHY_ADDR_REG, '0, rdata, waits);
        check_value("csr_readdata", rdata,
                    {{(CSR_DATA_W-PHY_ADDR_W){1'b0}}, addr_word[PHY_ADDR_W-1:0]});
        check_value("csr_waitrequest cycles", waits, 1);
        phy = addr_word[PHY_ADDR_W-1:0];
        report_test("address_register", first_err);

        first_err = errors;
        base      = frame_log.size();
        rnd       = $urandom;
        reg_a     = rnd[REG_ADDR_W-1:0];
        data_a    = $urandom;
        csr_access(1'b1, {1'b0, reg_a}, data_a, rdata, waits);
        check_value("csr_waitrequest cycles", waits, 1);
        wait_for_frames(base + 1);
        check_frame(base, op_write, phy, reg_a, data_a[MDIO_DATA_W-1:0]);
        report_test("preamble_and_write", first_err);

        first_err      = errors;
        base           = frame_log.size();
        rnd            = $urandom;
        phy_read_value = rnd[MDIO_DATA_W-1:0];
        rnd            = $urandom;
        reg_a          = rnd[REG_ADDR_W-1:0];
        csr_access(1'b0, {1'b0, reg_a}, '0, rdata, waits);
        check_value("csr_readdata", rdata, {{(CSR_DATA_W-MDIO_DATA_W){1'b0}}, phy_read_value});
        wait_for_frames(base + 1);
        check_frame(base, op_read, phy, reg_a, phy_read_value);
        report_test("read", first_err);

        // Second write stalls behind the frame of the first
        first_err = errors;
        base      = frame_log.size();
        rnd       = $urandom;
        reg_a     = rnd[REG_ADDR_W-1:0];
        reg_b     = rnd[2*REG_ADDR_W-1:REG_ADDR_W];
        data_a    = $urandom;
        data_b    = $urandom;
        csr_access(1'b1, {1'b0, reg_a}, data_a, rdata, waits);
        check_value("csr_waitrequest cycles", waits, 1);
        csr_access(1'b1, {1'b0, reg_b}, data_b, rdata, waits);
        checks = checks + 1;
        assert (waits >= MIN_STALL) else begin
            $display("Second write went through after %0d cycles, before the first frame ended",
                     waits);
            errors = errors + 1;
        end
        check_value("frames seen at accept", frame_log.size(), base + 1);
        wait_for_frames(base + 2);
        check_frame(base, op_write, phy, reg_a, data_a[MDIO_DATA_W-1:0]);
        check_frame(base + 1, op_write, phy, reg_b, data_b[MDIO_DATA_W-1:0]);
        report_test("back_pressure", first_err);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mdio_phy_model.sv
`timescale 1ns/1ns
`default_nettype none

// Clause 22 PHY that follows the MDIO frames on rising mdc
module mdio_phy_model import mdio_frame_pkg::*; (
    input  logic                   mdc,
    input  logic                   mdio_out,
    input  logic                   mdio_oen,
    input  logic [MDIO_DATA_W-1:0] read_value,
    output logic                   mdio_in,
    output logic [7:0]             pre_ones,
    output logic [1:0]             start_bits,
    output logic [1:0]             op_bits,
    output logic [PHY_ADDR_W-1:0]  phy_addr,
    output logic [REG_ADDR_W-1:0]  reg_addr,
    output logic [1:0]             ta_bits,
    output logic [MDIO_DATA_W-1:0] data,
    output logic [31:0]            frame_cnt
);

    int          ones;
    int          i;
    logic        found;
    logic [13:0] header;

    initial begin
        mdio_in    = 1'b1;
        pre_ones   = '0;
        start_bits = '0;
        op_bits    = '0;
        phy_addr   = '0;
        reg_addr   = '0;
        ta_bits    = '0;
        data       = '0;
        frame_cnt  = '0;
        forever begin
            // --------------------
            // Preamble hunt
            // --------------------
            // Driven ones count, a driven zero after enough of them is the start bit
            ones  = 0;
            found = 1'b0;
            while (!found) begin
                @(posedge mdc);
                if (!mdio_oen && mdio_out) begin
                    ones = ones + 1;
                end else if (!mdio_oen && ones >= PREAMBLE_BITS) begin
                    found = 1'b1;
                end else begin
                    ones = 0;
                end
            end
            pre_ones   = 8'(ones);
            header[13] = mdio_out;
            for (i = 12; i >= 0; i--) begin
                @(posedge mdc);
                header[i] = mdio_out;
            end
            {start_bits, op_bits, phy_addr, reg_addr} = header;

            // --------------------
            // Turnaround and data
            // --------------------
            @(posedge mdc);
            ta_bits[1] = mdio_out;
            if (op_bits == op_read) begin
                // PHY pulls the second turnaround bit low
                @(negedge mdc);
                mdio_in = 1'b0;
                @(posedge mdc);
                ta_bits[0] = mdio_out;
                data       = read_value;
                for (i = MDIO_DATA_W - 1; i >= 0; i--) begin
                    @(negedge mdc);
                    mdio_in = data[i];
                    @(posedge mdc);
                end
                @(negedge mdc);
                mdio_in = 1'b1;
            end else begin
                @(posedge mdc);
                ta_bits[0] = mdio_out;
                for (i = MDIO_DATA_W - 1; i >= 0; i--) begin
                    @(posedge mdc);
                    data[i] = mdio_out;
                end
            end
            frame_cnt = frame_cnt + 1;
        end
    end

endmodule

`default_nettype wire

// File: design/mdio_master.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_master import mdio_csr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_read,
    input  logic                  csr_write,
    input  logic [CSR_ADDR_W-1:0] csr_address,
    input  logic [CSR_DATA_W-1:0] csr_writedata,
    output logic [CSR_DATA_W-1:0] csr_readdata,
    output logic                  csr_waitrequest,
    output logic                  mdc,
    input  logic                  mdio_in,
    output logic                  mdio_out,
    output logic                  mdio_oen
);

    logic tick;
    logic sample;

    mdio_req_if req_if ();
    mdio_cmd_if cmd_if ();

    mdio_csr_slave u_slave (
        .clk             (clk),
        .reset           (reset),
        .csr_read        (csr_read),
        .csr_write       (csr_write),
        .csr_address     (csr_address),
        .csr_writedata   (csr_writedata),
        .csr_readdata    (csr_readdata),
        .csr_waitrequest (csr_waitrequest),
        .req             (req_if.slave)
    );

    mdio_cmd_buffer u_buffer (
        .clk   (clk),
        .reset (reset),
        .req   (req_if.buffer),
        .cmd   (cmd_if.buffer)
    );

    // MDC and its strobes feed the engine
    mdc_clock_gen u_mdc (
        .clk    (clk),
        .reset  (reset),
        .mdc    (mdc),
        .tick   (tick),
        .sample (sample)
    );

    mdio_frame_engine u_engine (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .sample   (sample),
        .mdio_in  (mdio_in),
        .mdio_out (mdio_out),
        .mdio_oen (mdio_oen),
        .cmd      (cmd_if.engine)
    );

endmodule

`default_nettype wire

// File: design/mdio_frame_engine.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_frame_engine import mdio_frame_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       sample,
    input  logic       mdio_in,
    output logic       mdio_out,
    output logic       mdio_oen,
    mdio_cmd_if.engine cmd
);

    typedef logic [$clog2(PREAMBLE_BITS)-1:0] bit_cnt_t;

    engine_state_e          state;
    bit_cnt_t               bit_cnt;
    logic                   finish_q;
    logic                   last_preamble;
    logic                   last_header;
    logic [MDIO_DATA_W-1:0] header_bits;
    logic [MDIO_DATA_W-1:0] shift_q;
    logic [MDIO_DATA_W-1:0] rdata_q;

    assign cmd.finish = finish_q;
    assign cmd.rdata  = rdata_q;

    // Start, opcode, PHY, register, turnaround
    assign header_bits = {2'b01, cmd.op, cmd.phy_addr, cmd.reg_addr, 2'b10};

    assign last_preamble = (bit_cnt == bit_cnt_t'(PREAMBLE_BITS - 1));
    assign last_header   = (bit_cnt == bit_cnt_t'(MDIO_DATA_W - 1));

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_reset_preamble;
            bit_cnt  <= '0;
            mdio_out <= 1'b1;
            mdio_oen <= 1'b1;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (tick) begin
                case (state)
                    // Line left to the pull-up, also used for recovery
                    st_reset_preamble: begin
                        mdio_oen <= 1'b1;
                        mdio_out <= 1'b1;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (last_preamble) begin
                            state <= st_idle;
                        end
                    end
                    st_idle: begin
                        bit_cnt <= '0;
                        if (cmd.pending) begin
                            state <= st_preamble;
                        end
                    end
                    st_preamble: begin
                        mdio_oen <= 1'b0;
                        mdio_out <= 1'b1;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (last_preamble) begin
                            bit_cnt <= '0;
                            state   <= st_header;
                        end
                    end
                    st_header: begin
                        mdio_out <= shift_q[MDIO_DATA_W-1];
                        bit_cnt  <= bit_cnt + 1'b1;
                        // Release the line for the PHY at turnaround
                        if (cmd.op == op_read && bit_cnt == bit_cnt_t'(MDIO_DATA_W - 2)) begin
                            mdio_oen <= 1'b1;
                        end
                        if (last_header) begin
                            bit_cnt <= '0;
                            state   <= (cmd.op == op_read) ? st_read_data : st_write_data;
                        end
                    end
                    st_write_data, st_read_data: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (state == st_write_data) begin
                            mdio_out <= shift_q[MDIO_DATA_W-1];
                        end
                        if (bit_cnt == bit_cnt_t'(MDIO_DATA_W)) begin
                            mdio_oen <= 1'b1;
                            mdio_out <= 1'b1;
                            finish_q <= 1'b1;
                            bit_cnt  <= bit_cnt_t'(PREAMBLE_BITS - RECOVERY_TICKS);
                            state    <= st_reset_preamble;
                        end
                    end
                    default: state <= st_reset_preamble;
                endcase
            end
        end
    end

    // --------------------
    // Shift registers
    // --------------------
    always_ff @(posedge clk) begin
        if (tick) begin
            if (state == st_preamble && last_preamble) begin
                shift_q <= header_bits;
            end else if (state == st_header && last_header) begin
                shift_q <= cmd.wdata;
            end else if (state == st_header || state == st_write_data) begin
                shift_q <= shift_q << 1;
            end
        end
        // First sample in this state still falls in turnaround
        if (sample && state == st_read_data && bit_cnt != '0) begin
            rdata_q <= {rdata_q[MDIO_DATA_W-2:0], mdio_in};
        end
    end

    a_read_released: assert property (@(posedge clk) disable iff (reset)
        state == st_read_data |-> mdio_oen);

endmodule

`default_nettype wire

// File: design/mdc_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module mdc_clock_gen import mdio_frame_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic mdc,
    output logic tick,
    output logic sample
);

    typedef logic [$clog2(MDC_HALF)-1:0] div_cnt_t;

    div_cnt_t div_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mdc     <= 1'b0;
            div_cnt <= '0;
            tick    <= 1'b0;
            sample  <= 1'b0;
        end else begin
            // Half-period down-counter
            if (div_cnt == '0) begin
                mdc     <= ~mdc;
                div_cnt <= div_cnt_t'(MDC_HALF - 1);
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end

            // Drive point, just after mdc has fallen
            tick   <= ~mdc && (div_cnt == div_cnt_t'(MDC_HALF - 1));
            // Capture point, the last clk before mdc rises
            sample <= ~mdc && (div_cnt == div_cnt_t'(1));
        end
    end

    a_strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(tick && sample));

endmodule

`default_nettype wire

// File: design/mdio_cmd_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_cmd_buffer import mdio_frame_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    mdio_req_if.buffer req,
    mdio_cmd_if.buffer cmd
);

    logic                   pending_q;
    logic                   done_q;
    logic [MDIO_DATA_W-1:0] rdata_q;

    assign cmd.pending = pending_q;
    assign req.empty   = !pending_q;
    assign req.done    = done_q;
    assign req.rdata   = rdata_q;

    // Slot occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (req.push) begin
                pending_q <= 1'b1;
            end else if (cmd.finish) begin
                pending_q <= 1'b0;
                done_q    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.push) begin
            cmd.op       <= req.op;
            cmd.phy_addr <= req.phy_addr;
            cmd.reg_addr <= req.reg_addr;
            cmd.wdata    <= req.wdata;
        end
        if (cmd.finish) begin
            rdata_q <= cmd.rdata;
        end
    end

    // The engine relies on the fields for the whole frame
    a_fields_stable: assert property (@(posedge clk) disable iff (reset)
        cmd.pending |=> !cmd.pending ||
            $stable({cmd.op, cmd.phy_addr, cmd.reg_addr, cmd.wdata}));

endmodule

`default_nettype wire

// File: design/mdio_csr_slave.sv
`timescale 1ns/1ns
`default_nettype none

module mdio_csr_slave import mdio_frame_pkg::*, mdio_csr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_read,
    input  logic                  csr_write,
    input  logic [CSR_ADDR_W-1:0] csr_address,
    input  logic [CSR_DATA_W-1:0] csr_writedata,
    output logic [CSR_DATA_W-1:0] csr_readdata,
    output logic                  csr_waitrequest,
    mdio_req_if.slave             req
);

    logic                  csr_req;
    logic                  addr_hit;
    logic                  mdio_hit;
    logic                  accept_mdio;
    logic                  accept_local;
    logic                  read_wait;
    logic [PHY_ADDR_W-1:0] phy_reg;

    // --------------------
    // Address decode
    // --------------------
    assign csr_req  = csr_read || csr_write;
    assign addr_hit = (csr_address == CSR_PHY_ADDR_REG);
    assign mdio_hit = (csr_address[CSR_ADDR_W-1:REG_ADDR_W] == '0);

    // Only a fresh request is taken, never one that was just answered
    assign accept_mdio  = csr_req && csr_waitrequest && !read_wait && mdio_hit && req.empty;
    assign accept_local = csr_req && csr_waitrequest && !read_wait && !mdio_hit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            csr_waitrequest <= 1'b1;
            csr_readdata    <= '0;
            phy_reg         <= '0;
            read_wait       <= 1'b0;
            req.push        <= 1'b0;
        end else begin
            csr_waitrequest <= 1'b1;
            req.push        <= accept_mdio;
            if (read_wait) begin
                // Hold the bus until the frame has returned its data
                if (req.done) begin
                    csr_waitrequest <= 1'b0;
                    csr_readdata    <= {{(CSR_DATA_W-MDIO_DATA_W){1'b0}}, req.rdata};
                    read_wait       <= 1'b0;
                end
            end else if (accept_mdio) begin
                if (csr_write) begin
                    csr_waitrequest <= 1'b0;
                end else begin
                    read_wait <= 1'b1;
                end
            end else if (accept_local) begin
                csr_waitrequest <= 1'b0;
                if (addr_hit && csr_write) begin
                    phy_reg <= csr_writedata[PHY_ADDR_W-1:0];
                end
                // Unmapped addresses read as zero
                if (csr_read) begin
                    csr_readdata <= addr_hit ? {{(CSR_DATA_W-PHY_ADDR_W){1'b0}}, phy_reg} : '0;
                end
            end
        end
    end

    // Command fields, latched with the push
    always_ff @(posedge clk) begin
        if (accept_mdio) begin
            req.op       <= csr_write ? op_write : op_read;
            req.phy_addr <= phy_reg;
            req.reg_addr <= csr_address[REG_ADDR_W-1:0];
            req.wdata    <= csr_writedata[MDIO_DATA_W-1:0];
        end
    end

    a_push_when_empty: assert property (@(posedge clk) disable iff (reset)
        req.push |-> req.empty);

endmodule

`default_nettype wire

// File: design/mdio_cmd_if.sv
`timescale 1ns/1ns
`default_nettype none

// Request path from the CSR slave into the command slot
interface mdio_req_if import mdio_frame_pkg::*; ();
    logic                   push;
    mdio_op_e               op;
    logic [PHY_ADDR_W-1:0]  phy_addr;
    logic [REG_ADDR_W-1:0]  reg_addr;
    logic [MDIO_DATA_W-1:0] wdata;
    logic                   empty;
    logic                   done;
    logic [MDIO_DATA_W-1:0] rdata;

    modport slave (output push, op, phy_addr, reg_addr, wdata, input empty, done, rdata);
    modport buffer (input push, op, phy_addr, reg_addr, wdata, output empty, done, rdata);
endinterface

// Held command from the slot into the frame engine
interface mdio_cmd_if import mdio_frame_pkg::*; ();
    logic                   pending;
    mdio_op_e               op;
    logic [PHY_ADDR_W-1:0]  phy_addr;
    logic [REG_ADDR_W-1:0]  reg_addr;
    logic [MDIO_DATA_W-1:0] wdata;
    logic                   finish;
    logic [MDIO_DATA_W-1:0] rdata;

    modport buffer (output pending, op, phy_addr, reg_addr, wdata, input finish, rdata);
    modport engine (input pending, op, phy_addr, reg_addr, wdata, output finish, rdata);
endinterface

`default_nettype wire

// File: design/mdio_csr_pkg.sv
`default_nettype none

package mdio_csr_pkg;

    // --------------------
    // CSR bus widths
    // --------------------
    localparam int CSR_ADDR_W = 6;
    localparam int CSR_DATA_W = 32;

    // --------------------
    // Register map
    // --------------------
    // Word addresses 0 to 31 map onto the PHY registers
    localparam logic [CSR_ADDR_W-1:0] CSR_PHY_ADDR_REG = 6'h21;

endpackage

`default_nettype wire

// File: design/mdio_frame_pkg.sv
`default_nettype none

package mdio_frame_pkg;

    // --------------------
    // MDC timing
    // --------------------
    // Kept small so that simulation runs fast
    localparam int MDC_DIVISOR = 8;
    localparam int MDC_HALF    = MDC_DIVISOR / 2;

    // --------------------
    // Frame layout
    // --------------------
    localparam int PREAMBLE_BITS  = 32;
    localparam int RECOVERY_TICKS = 2;
    localparam int PHY_ADDR_W     = 5;
    localparam int REG_ADDR_W     = 5;
    localparam int MDIO_DATA_W    = 16;

    // Clause 22 opcodes as they appear on the wire
    typedef enum logic [1:0] {
        op_write = 2'b01,
        op_read  = 2'b10
    } mdio_op_e;

    typedef enum logic [2:0] {
        st_reset_preamble,
        st_idle,
        st_preamble,
        st_header,
        st_write_data,
        st_read_data
    } engine_state_e;

endpackage

`default_nettype wire
